/* logic/nl_pkg.sv */
`default_nettype none

package nl_pkg;

	// Datapath sizes
	localparam int n_lanes = 4;
	localparam int lane_w = 8;
	localparam int word_w = n_lanes * lane_w;
	localparam int buf_depth = 256;
	localparam int buf_addr_w = 8;
	localparam int lut_size = 64;
	localparam int lut_addr_w = 6;
	localparam int n_segments = 8;

	typedef logic signed [lane_w-1:0] act_t;
	typedef logic [word_w-1:0] word_t;
	typedef logic [buf_addr_w-1:0] buf_addr_t;
	typedef logic [lut_addr_w-1:0] lut_addr_t;
	typedef logic [7:0] shift_t;

	typedef enum logic [2:0] {
		func_relu = 3'd0,
		func_sigmoid = 3'd3,
		func_tanh = 3'd4
	} nl_func_t;

	typedef enum logic [2:0] {
		st_idle,
		st_pre_read,
		st_read,
		st_operate,
		st_write
	} nl_state_t;

	// Coefficient table layout
	localparam int sig_hdr_base = 0;
	localparam int tanh_hdr_base = 5;
	localparam int sig_x_init_base = 10;
	localparam int sig_a_base = 18;
	localparam int sig_b_base = 26;
	localparam int tanh_x_init_base = 34;
	localparam int tanh_a_base = 42;
	localparam int tanh_b_base = 50;

	// Offsets inside a function header
	localparam int hdr_shift_addr = 0;
	localparam int hdr_x_min = 1;
	localparam int hdr_x_max = 2;
	localparam int hdr_y_min = 3;
	localparam int hdr_y_max = 4;

	typedef struct packed {
		act_t shift_addr;
		act_t x_min;
		act_t x_max;
		act_t y_min;
		act_t y_max;
		act_t [n_segments-1:0] x_init;
		act_t [n_segments-1:0] a;
		act_t [n_segments-1:0] b;
	} pwl_params_t;

	typedef struct packed {
		nl_func_t func;
		shift_t frac_shift;
		logic [buf_addr_w:0] n_words;
	} nl_cfg_t;

endpackage

`default_nettype wire

/* logic/act_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module act_buffer (
	input wire logic clk,
	input wire logic wr_en,
	input nl_pkg::buf_addr_t wr_addr,
	input nl_pkg::word_t wr_data,
	input wire logic rd_en,
	input nl_pkg::buf_addr_t rd_addr,
	output nl_pkg::word_t rd_word
);

	nl_pkg::word_t mem [nl_pkg::buf_depth];

	// Filled from outside before a run
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Output word holds between reads
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_word <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

/* logic/coef_lut.sv */
`timescale 1ns/10ps
`default_nettype none

module coef_lut (
	input wire logic clk,
	input wire logic reset,
	input wire logic wr_en,
	input nl_pkg::lut_addr_t wr_addr,
	input nl_pkg::act_t wr_data,
	input nl_pkg::nl_func_t func,
	output nl_pkg::pwl_params_t params
);

	nl_pkg::act_t lut [nl_pkg::lut_size];
	nl_pkg::pwl_params_t sig_params;
	nl_pkg::pwl_params_t tanh_params;

	// Collect one function's header and segment arrays
	function automatic nl_pkg::pwl_params_t gather(
		input nl_pkg::act_t tbl [nl_pkg::lut_size],
		input int hdr_base,
		input int x_base,
		input int a_base,
		input int b_base
	);
		nl_pkg::pwl_params_t p;
		p.shift_addr = tbl[hdr_base + nl_pkg::hdr_shift_addr];
		p.x_min = tbl[hdr_base + nl_pkg::hdr_x_min];
		p.x_max = tbl[hdr_base + nl_pkg::hdr_x_max];
		p.y_min = tbl[hdr_base + nl_pkg::hdr_y_min];
		p.y_max = tbl[hdr_base + nl_pkg::hdr_y_max];
		for (int i = 0; i < nl_pkg::n_segments; i++) begin
			p.x_init[i] = tbl[x_base + i];
			p.a[i] = tbl[a_base + i];
			p.b[i] = tbl[b_base + i];
		end
		return p;
	endfunction

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < nl_pkg::lut_size; i++) begin
				lut[i] <= '0;
			end
		end else if (wr_en) begin
			lut[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		sig_params = gather(lut, nl_pkg::sig_hdr_base, nl_pkg::sig_x_init_base,
			nl_pkg::sig_a_base, nl_pkg::sig_b_base);
		tanh_params = gather(lut, nl_pkg::tanh_hdr_base, nl_pkg::tanh_x_init_base,
			nl_pkg::tanh_a_base, nl_pkg::tanh_b_base);
	end

	// Sigmoid set doubles as the default for ReLU and unknown codes
	assign params = (func == nl_pkg::func_tanh) ? tanh_params : sig_params;

endmodule

`default_nettype wire

/* logic/pwl_lane.sv */
`timescale 1ns/10ps
`default_nettype none

module pwl_lane (
	input nl_pkg::act_t x,
	input nl_pkg::nl_func_t func,
	input nl_pkg::pwl_params_t params,
	input nl_pkg::shift_t frac_shift,
	output nl_pkg::act_t y
);

	nl_pkg::act_t x_key;
	nl_pkg::act_t seg_key;
	nl_pkg::act_t a_sel;
	nl_pkg::act_t b_sel;
	nl_pkg::act_t relu_y;
	nl_pkg::act_t pwl_y;
	logic [2:0] seg;
	logic signed [15:0] prod;
	logic signed [15:0] b_shifted;
	logic signed [15:0] acc;
	logic signed [15:0] acc_shifted;

	assign relu_y = (x > 0) ? x : '0;

	// Segment search, later matches win
	always_comb begin
		x_key = x >>> params.shift_addr;
		seg = '0;
		for (int i = 0; i < nl_pkg::n_segments; i++) begin
			seg_key = $signed(params.x_init[i]) >>> params.shift_addr;
			if (seg_key == x_key) begin
				seg = 3'(i);
			end
		end
	end

	// a*x + (b << frac), then back to activation scale
	always_comb begin
		a_sel = params.a[seg];
		b_sel = params.b[seg];
		prod = a_sel * x;
		b_shifted = {{8{b_sel[7]}}, b_sel} <<< frac_shift;
		acc = prod + b_shifted;
		acc_shifted = acc >>> frac_shift;
	end

	always_comb begin
		if (x <= $signed(params.x_min)) begin
			pwl_y = params.y_min;
		end else if (x >= $signed(params.x_max)) begin
			pwl_y = params.y_max;
		end else begin
			pwl_y = acc_shifted[7:0];
		end
	end

	assign y = (func == nl_pkg::func_relu) ? relu_y : pwl_y;

endmodule

`default_nettype wire

/* logic/nl_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module nl_sequencer (
	input wire logic clk,
	input wire logic reset,
	input wire logic enable,
	input nl_pkg::nl_cfg_t cfg,
	input nl_pkg::word_t lane_y,
	output logic rd_en,
	output nl_pkg::buf_addr_t rd_addr,
	output logic wr_en,
	output nl_pkg::buf_addr_t wr_addr,
	output nl_pkg::word_t wr_word,
	output logic finished
);

	nl_pkg::nl_state_t state;
	nl_pkg::nl_state_t next_state;
	logic [nl_pkg::buf_addr_w:0] counter;
	nl_pkg::word_t result_q;

	assign finished = (counter == cfg.n_words);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= nl_pkg::st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			nl_pkg::st_idle: begin
				if (enable) begin
					case (cfg.func)
						nl_pkg::func_relu,
						nl_pkg::func_sigmoid,
						nl_pkg::func_tanh: next_state = nl_pkg::st_pre_read;
						default: next_state = nl_pkg::st_idle;
					endcase
				end
			end
			nl_pkg::st_pre_read: begin
				next_state = finished ? nl_pkg::st_idle : nl_pkg::st_read;
			end
			nl_pkg::st_read: next_state = nl_pkg::st_operate;
			nl_pkg::st_operate: next_state = nl_pkg::st_write;
			nl_pkg::st_write: begin
				next_state = finished ? nl_pkg::st_idle : nl_pkg::st_pre_read;
			end
			default: next_state = nl_pkg::st_idle;
		endcase
	end

	// Cleared only once the host lets go of enable, so a held enable
	// after finished just bounces through pre_read
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			counter <= '0;
		end else if (state == nl_pkg::st_idle && !enable) begin
			counter <= '0;
		end else if (enable && state == nl_pkg::st_write) begin
			counter <= counter + 1'b1;
		end
	end

	assign rd_addr = counter[nl_pkg::buf_addr_w-1:0];
	assign wr_addr = counter[nl_pkg::buf_addr_w-1:0];

	// Two read cycles, the second one lines up with the lane inputs
	assign rd_en = (state == nl_pkg::st_pre_read && !finished) || (state == nl_pkg::st_read);
	assign wr_en = (state == nl_pkg::st_write);

	always_ff @(posedge clk) begin
		if (state == nl_pkg::st_operate) begin
			result_q <= lane_y;
		end
	end

	assign wr_word = result_q;

endmodule

`default_nettype wire

/* logic/result_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module result_buffer (
	input wire logic clk,
	input wire logic wr_en,
	input nl_pkg::buf_addr_t wr_addr,
	input nl_pkg::word_t wr_data,
	input nl_pkg::buf_addr_t rd_addr,
	output nl_pkg::word_t rd_data
);

	nl_pkg::word_t mem [nl_pkg::buf_depth];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Readback port for the host, one cycle latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* logic/nl_unit_top.sv */
`timescale 1ns/10ps
`default_nettype none

module nl_unit_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic lut_wr_en,
	input nl_pkg::lut_addr_t lut_wr_addr,
	input nl_pkg::act_t lut_wr_data,
	input wire logic in_wr_en,
	input nl_pkg::buf_addr_t in_wr_addr,
	input nl_pkg::word_t in_wr_data,
	input nl_pkg::nl_cfg_t cfg,
	input wire logic enable,
	output logic finished,
	input nl_pkg::buf_addr_t out_rd_addr,
	output nl_pkg::word_t out_rd_data
);

	logic rd_en;
	nl_pkg::buf_addr_t rd_addr;
	nl_pkg::word_t rd_word;
	nl_pkg::pwl_params_t params;
	nl_pkg::word_t lane_y;
	logic wr_en;
	nl_pkg::buf_addr_t wr_addr;
	nl_pkg::word_t wr_word;

	act_buffer in_buf0 (
		.clk(clk),
		.wr_en(in_wr_en),
		.wr_addr(in_wr_addr),
		.wr_data(in_wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_word(rd_word)
	);

	coef_lut lut0 (
		.clk(clk),
		.reset(reset),
		.wr_en(lut_wr_en),
		.wr_addr(lut_wr_addr),
		.wr_data(lut_wr_data),
		.func(cfg.func),
		.params(params)
	);

	// One evaluator per activation in the word
	for (genvar i = 0; i < nl_pkg::n_lanes; i++) begin : g_lane
		pwl_lane lane0 (
			.x(rd_word[i*nl_pkg::lane_w +: nl_pkg::lane_w]),
			.func(cfg.func),
			.params(params),
			.frac_shift(cfg.frac_shift),
			.y(lane_y[i*nl_pkg::lane_w +: nl_pkg::lane_w])
		);
	end

	nl_sequencer seq0 (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.cfg(cfg),
		.lane_y(lane_y),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_word(wr_word),
		.finished(finished)
	);

	result_buffer out_buf0 (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_word),
		.rd_addr(out_rd_addr),
		.rd_data(out_rd_data)
	);

endmodule

`default_nettype wire

/* include/nl_tb_cases.svh */
`ifndef NL_TB_CASES_SVH
`define NL_TB_CASES_SVH

// One run of the block with func as a raw 3-bit code
typedef struct packed {
	logic [8*12-1:0] name;
	logic [2:0] func;
	nl_pkg::shift_t frac_shift;
	logic [nl_pkg::buf_addr_w:0] n_words;
	logic rand_words;
	nl_pkg::word_t [3:0] words;
} nl_case_t;

localparam int tb_n_cases = 9;

// Words are listed from index 3 down to index 0
localparam nl_case_t tb_cases [tb_n_cases] = '{
	'{"relu_fixed", 3'd0, 8'd0, 9'd2, 1'b0,
		{32'h0, 32'h0, 32'h12ed_3cc4, 32'h7f80_0100}},
	'{"relu_rand", 3'd0, 8'd0, 9'd4, 1'b1, {4{32'h0}}},
	'{"sig_bounds", 3'd3, 8'd4, 9'd2, 1'b0,
		{32'h0, 32'h0, 32'h10f0_25d5, 32'hc080_3f7f}},
	'{"sig_rand", 3'd3, 8'd5, 9'd4, 1'b1, {4{32'h0}}},
	'{"tanh_s4", 3'd4, 8'd4, 9'd3, 1'b0,
		{32'h0, 32'h7f00_2cd0, 32'h3ec1_119a, 32'h20e0_05fb}},
	'{"tanh_s6", 3'd4, 8'd6, 9'd3, 1'b0,
		{32'h0, 32'h0a3a_c6f6, 32'h1bd8_3380, 32'h2de4_0c13}},
	'{"bad_func", 3'd2, 8'd4, 9'd2, 1'b0, {4{32'h0}}},
	'{"multi_long", 3'd0, 8'd0, 9'd4, 1'b1, {4{32'h0}}},
	'{"multi_short", 3'd0, 8'd0, 9'd2, 1'b0,
		{32'h0, 32'h0, 32'h8001_7ffe, 32'h0102_fdfc}}
};

`endif

/* testbench/nl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module nl_tb;

	`include "nl_tb_cases.svh"

	logic clk;
	logic reset;
	logic lut_wr_en;
	nl_pkg::lut_addr_t lut_wr_addr;
	nl_pkg::act_t lut_wr_data;
	logic in_wr_en;
	nl_pkg::buf_addr_t in_wr_addr;
	nl_pkg::word_t in_wr_data;
	nl_pkg::nl_cfg_t cfg;
	logic enable;
	logic finished;
	nl_pkg::buf_addr_t out_rd_addr;
	nl_pkg::word_t out_rd_data;

	nl_pkg::act_t coef [nl_pkg::lut_size];
	nl_pkg::word_t exp_mem [nl_pkg::buf_depth];
	bit exp_valid [nl_pkg::buf_depth];
	int seed = 32'h9b8;
	int mismatch_errors = 0;
	int other_errors = 0;

	nl_unit_top dut0 (
		.clk(clk),
		.reset(reset),
		.lut_wr_en(lut_wr_en),
		.lut_wr_addr(lut_wr_addr),
		.lut_wr_data(lut_wr_data),
		.in_wr_en(in_wr_en),
		.in_wr_addr(in_wr_addr),
		.in_wr_data(in_wr_data),
		.cfg(cfg),
		.enable(enable),
		.finished(finished),
		.out_rd_addr(out_rd_addr),
		.out_rd_data(out_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Drive and sample point 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic build_coefs();
		int sig_a [8] = '{1, 2, 4, 7, 8, 5, 3, -1};
		int sig_b [8] = '{4, 10, 18, 30, 34, 46, 56, 62};
		int tanh_a [8] = '{2, 5, 9, 14, 15, 10, 6, 3};
		int tanh_b [8] = '{-60, -48, -30, -10, 6, 28, 44, 58};
		for (int i = 0; i < nl_pkg::lut_size; i++) begin
			coef[i] = '0;
		end
		coef[nl_pkg::sig_hdr_base + nl_pkg::hdr_shift_addr] = 8'sd4;
		coef[nl_pkg::sig_hdr_base + nl_pkg::hdr_x_min] = -8'sd64;
		coef[nl_pkg::sig_hdr_base + nl_pkg::hdr_x_max] = 8'sd63;
		coef[nl_pkg::sig_hdr_base + nl_pkg::hdr_y_min] = 8'sd0;
		coef[nl_pkg::sig_hdr_base + nl_pkg::hdr_y_max] = 8'sd64;
		coef[nl_pkg::tanh_hdr_base + nl_pkg::hdr_shift_addr] = 8'sd4;
		coef[nl_pkg::tanh_hdr_base + nl_pkg::hdr_x_min] = -8'sd56;
		coef[nl_pkg::tanh_hdr_base + nl_pkg::hdr_x_max] = 8'sd56;
		coef[nl_pkg::tanh_hdr_base + nl_pkg::hdr_y_min] = -8'sd64;
		coef[nl_pkg::tanh_hdr_base + nl_pkg::hdr_y_max] = 8'sd64;
		// Segment starts every 16 steps from -64
		for (int i = 0; i < nl_pkg::n_segments; i++) begin
			coef[nl_pkg::sig_x_init_base + i] = nl_pkg::act_t'(-64 + 16 * i);
			coef[nl_pkg::tanh_x_init_base + i] = nl_pkg::act_t'(-64 + 16 * i);
			coef[nl_pkg::sig_a_base + i] = nl_pkg::act_t'(sig_a[i]);
			coef[nl_pkg::sig_b_base + i] = nl_pkg::act_t'(sig_b[i]);
			coef[nl_pkg::tanh_a_base + i] = nl_pkg::act_t'(tanh_a[i]);
			coef[nl_pkg::tanh_b_base + i] = nl_pkg::act_t'(tanh_b[i]);
		end
	endtask

	function automatic nl_pkg::act_t lane_model(nl_pkg::act_t x, logic [2:0] func, int fs);
		int hdr;
		int xb;
		int ab;
		int bb;
		int sa;
		int seg;
		int prod;
		int bsh;
		nl_pkg::act_t xk;
		logic signed [15:0] acc;
		logic signed [15:0] sh;
		if (func == 3'd0) begin
			return (x > 0) ? x : nl_pkg::act_t'(0);
		end
		hdr = (func == 3'd4) ? nl_pkg::tanh_hdr_base : nl_pkg::sig_hdr_base;
		xb = (func == 3'd4) ? nl_pkg::tanh_x_init_base : nl_pkg::sig_x_init_base;
		ab = (func == 3'd4) ? nl_pkg::tanh_a_base : nl_pkg::sig_a_base;
		bb = (func == 3'd4) ? nl_pkg::tanh_b_base : nl_pkg::sig_b_base;
		if (x <= coef[hdr + nl_pkg::hdr_x_min]) begin
			return coef[hdr + nl_pkg::hdr_y_min];
		end
		if (x >= coef[hdr + nl_pkg::hdr_x_max]) begin
			return coef[hdr + nl_pkg::hdr_y_max];
		end
		sa = coef[hdr + nl_pkg::hdr_shift_addr];
		xk = x >>> sa;
		seg = 0;
		for (int i = 0; i < nl_pkg::n_segments; i++) begin
			if ((coef[xb + i] >>> sa) == xk) begin
				seg = i;
			end
		end
		prod = coef[ab + seg] * x;
		bsh = int'(coef[bb + seg]) * (1 << fs);
		// 16-bit accumulator wraps like the hardware
		acc = 16'(prod + bsh);
		sh = acc >>> fs;
		return nl_pkg::act_t'(sh[7:0]);
	endfunction

	function automatic nl_pkg::word_t word_model(nl_pkg::word_t w, logic [2:0] func, int fs);
		nl_pkg::word_t r;
		for (int l = 0; l < nl_pkg::n_lanes; l++) begin
			r[l*nl_pkg::lane_w +: nl_pkg::lane_w] =
				lane_model(w[l*nl_pkg::lane_w +: nl_pkg::lane_w], func, fs);
		end
		return r;
	endfunction

	task automatic program_lut();
		for (int a = 0; a < nl_pkg::lut_size; a++) begin
			step();
			lut_wr_en = 1'b1;
			lut_wr_addr = nl_pkg::lut_addr_t'(a);
			lut_wr_data = coef[a];
		end
		step();
		lut_wr_en = 1'b0;
	endtask

	// Every address written so far must still hold its last result
	task automatic read_back(logic [8*12-1:0] name);
		nl_pkg::word_t got;
		for (int a = 0; a < nl_pkg::buf_depth; a++) begin
			if (exp_valid[a]) begin
				step();
				out_rd_addr = nl_pkg::buf_addr_t'(a);
				step();
				got = out_rd_data;
				assert (got === exp_mem[a]) else begin
					$display("Mismatch in %s at word %0d: expected %h, actual %h",
						name, a, exp_mem[a], got);
					mismatch_errors++;
				end
			end
		end
	endtask

	task automatic run_case(int c);
		nl_case_t tc;
		nl_pkg::word_t w;
		int n;
		bit supported;
		tc = tb_cases[c];
		n = tc.n_words;
		supported = (tc.func == 3'd0) || (tc.func == 3'd3) || (tc.func == 3'd4);
		for (int k = 0; k < n; k++) begin
			w = tc.rand_words ? nl_pkg::word_t'($random(seed)) : tc.words[k];
			step();
			in_wr_en = 1'b1;
			in_wr_addr = nl_pkg::buf_addr_t'(k);
			in_wr_data = w;
			if (supported) begin
				exp_mem[k] = word_model(w, tc.func, tc.frac_shift);
				exp_valid[k] = 1'b1;
			end
		end
		step();
		in_wr_en = 1'b0;
		cfg.func = nl_pkg::nl_func_t'(tc.func);
		cfg.frac_shift = tc.frac_shift;
		cfg.n_words = tc.n_words;
		step();
		enable = 1'b1;
		if (supported) begin
			step();
			while (!finished) begin
				step();
			end
		end else begin
			// Idle keeps the counter at zero
			repeat (20) begin
				step();
				assert (finished === (tc.n_words == 0)) else begin
					$display("%s: finished changed while the function code is unsupported",
						tc.name);
					other_errors++;
				end
			end
		end
		enable = 1'b0;
		step();
		step();
		read_back(tc.name);
	endtask

	initial begin
		reset = 1'b0;
		lut_wr_en = 1'b0;
		lut_wr_addr = '0;
		lut_wr_data = '0;
		in_wr_en = 1'b0;
		in_wr_addr = '0;
		in_wr_data = '0;
		cfg.func = nl_pkg::func_relu;
		cfg.frac_shift = '0;
		cfg.n_words = '0;
		enable = 1'b0;
		out_rd_addr = '0;
		for (int a = 0; a < nl_pkg::buf_depth; a++) begin
			exp_valid[a] = 1'b0;
		end
		build_coefs();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b1;
		step();
		// Zero words configured means the run counts as done
		assert (finished === 1'b1) else begin
			$display("finished is low after reset with zero words configured");
			other_errors++;
		end
		program_lut();
		for (int c = 0; c < tb_n_cases; c++) begin
			run_case(c);
		end
		$display("Error counts: %0d mismatches, %0d other failures",
			mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		int budget;
		budget = 10 + nl_pkg::lut_size + 8;
		for (int c = 0; c < tb_n_cases; c++) begin
			budget += 4 * int'(tb_cases[c].n_words) + 40;
		end
		repeat (budget) @(posedge clk);
		$display("Timeout: the run did not complete within %0d cycles", budget);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* nl_unit.f */
+incdir+include
logic/nl_pkg.sv
logic/act_buffer.sv
logic/coef_lut.sv
logic/pwl_lane.sv
logic/nl_sequencer.sv
logic/result_buffer.sv
logic/nl_unit_top.sv
testbench/nl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f nl_unit.f \
	--top-module nl_tb -o nl_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/nl_sim > sim.log 2>&1 \
	|| { echo "Simulation exited with an error, see sim.log"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
